/* rv_isa_pkg.sv */
package rv_isa_pkg;

    // datapath and address width
    localparam int XLEN = 32;

    // register index width, x0..x31
    localparam int REG_ADDR_W = 5;

    // major opcodes, instruction bits [6:0]
    localparam logic [6:0] OP_LOAD  = 7'b000_0011;
    localparam logic [6:0] OP_STORE = 7'b010_0011;

    // funct3 width codes for loads and stores, instruction bits [14:12]
    // stores only use the signed encodings
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;

    // unsigned loads, zero extended
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

endpackage

/* pipe_pkg.sv */
package pipe_pkg;

    // data memory depth in 32-bit words
    localparam int DMEM_WORDS_DEFAULT = 256;

    // width of the retired instruction counter
    localparam int INSTRET_W = 32;

    // addi x0, x0, 0
    // the pipeline register holds this after reset or flush
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

/* mem_stage.sv */
`timescale 1ns/1ps

module mem_stage #(
    parameter int DMEM_WORDS = pipe_pkg::DMEM_WORDS_DEFAULT
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        mem_write,
    input  logic [rv_isa_pkg::XLEN-1:0] instruction,
    input  logic [rv_isa_pkg::XLEN-1:0] exec_result,
    input  logic [rv_isa_pkg::XLEN-1:0] store_data,
    output logic [rv_isa_pkg::XLEN-1:0] mem_rdata
);
    import rv_isa_pkg::*;

    localparam int NUM_LANES = XLEN / 8;
    localparam int IDX_W     = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    logic [XLEN-1:0]      dmem [DMEM_WORDS];
    logic [2:0]           funct3;
    logic [6:0]           opcode;
    logic [IDX_W-1:0]     word_idx;
    logic [1:0]           byte_off;
    logic [NUM_LANES-1:0] byte_en;
    logic [XLEN-1:0]      wdata;
    logic                 store_en;

    assign funct3   = instruction[14:12];
    assign opcode   = instruction[6:0];
    assign byte_off = exec_result[1:0];
    // word address, byte offset dropped
    assign word_idx = exec_result[IDX_W+1:2];

    // only a real store instruction may touch memory
    assign store_en = mem_write && (opcode == OP_STORE);

    // replicate the store value into every lane, byte_en picks the target
    always_comb begin
        byte_en = '0;
        wdata   = store_data;
        case (funct3)
            F3_B: begin
                byte_en = NUM_LANES'(1) << byte_off;
                wdata   = {NUM_LANES{store_data[7:0]}};
            end
            F3_H: begin
                byte_en = NUM_LANES'(2'b11) << {byte_off[1], 1'b0};
                wdata   = {(NUM_LANES/2){store_data[15:0]}};
            end
            F3_W: begin
                byte_en = '1;
                wdata   = store_data;
            end
            default: begin
                byte_en = '0;
            end
        endcase
    end

    // byte-enabled write, visible to a load on the next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < DMEM_WORDS; w++) begin
                dmem[w] <= '0;
            end
        end else if (store_en) begin
            for (int b = 0; b < NUM_LANES; b++) begin
                if (byte_en[b]) begin
                    dmem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // combinational read, captured by the MEM/WB register
    assign mem_rdata = dmem[word_idx];

endmodule

/* mem_wb_reg.sv */
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,
    input  logic                        flush,
    input  logic                        reg_write,
    input  logic [rv_isa_pkg::XLEN-1:0] instruction,
    input  logic [rv_isa_pkg::XLEN-1:0] pc,
    input  logic [rv_isa_pkg::XLEN-1:0] exec_result,
    input  logic                        mem_read,
    input  logic [rv_isa_pkg::XLEN-1:0] mem_rdata,
    input  logic                        ecall,
    output logic                        reg_write_wb,
    output logic [rv_isa_pkg::XLEN-1:0] instruction_wb,
    output logic [rv_isa_pkg::XLEN-1:0] pc_wb,
    output logic [rv_isa_pkg::XLEN-1:0] exec_result_wb,
    output logic                        mem_read_wb,
    output logic [rv_isa_pkg::XLEN-1:0] mem_rdata_wb,
    output logic                        ecall_wb
);
    import pipe_pkg::*;

    // stall has priority, flush only acts on a moving pipeline
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_write_wb   <= 1'b0;
            instruction_wb <= NOP_INSTR;
            pc_wb          <= '0;
            exec_result_wb <= '0;
            mem_read_wb    <= 1'b0;
            mem_rdata_wb   <= '0;
            ecall_wb       <= 1'b0;
        end else if (stall) begin
            // hold everything
            reg_write_wb   <= reg_write_wb;
            instruction_wb <= instruction_wb;
            pc_wb          <= pc_wb;
            exec_result_wb <= exec_result_wb;
            mem_read_wb    <= mem_read_wb;
            mem_rdata_wb   <= mem_rdata_wb;
            ecall_wb       <= ecall_wb;
        end else if (flush) begin
            // bubble
            reg_write_wb   <= 1'b0;
            instruction_wb <= NOP_INSTR;
            pc_wb          <= '0;
            exec_result_wb <= '0;
            mem_read_wb    <= 1'b0;
            mem_rdata_wb   <= '0;
            ecall_wb       <= 1'b0;
        end else begin
            reg_write_wb   <= reg_write;
            instruction_wb <= instruction;
            pc_wb          <= pc;
            exec_result_wb <= exec_result;
            mem_read_wb    <= mem_read;
            mem_rdata_wb   <= mem_rdata;
            ecall_wb       <= ecall;
        end
    end

endmodule

/* writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage #(
    parameter int INSTRET_W = pipe_pkg::INSTRET_W
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              stall,
    input  logic                              reg_write_wb,
    input  logic [rv_isa_pkg::XLEN-1:0]       instruction_wb,
    input  logic [rv_isa_pkg::XLEN-1:0]       exec_result_wb,
    input  logic                              mem_read_wb,
    input  logic [rv_isa_pkg::XLEN-1:0]       mem_rdata_wb,
    input  logic                              ecall_wb,
    output logic                              rf_we,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rf_waddr,
    output logic [rv_isa_pkg::XLEN-1:0]       rf_wdata,
    output logic                              halted,
    output logic [INSTRET_W-1:0]              instret
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [7:0]            load_byte;
    logic [15:0]           load_half;
    logic [XLEN-1:0]       load_ext;
    logic                  is_load;
    logic                  retire;

    assign opcode = instruction_wb[6:0];
    assign rd     = instruction_wb[11:7];
    assign funct3 = instruction_wb[14:12];

    // lane select from the address low bits
    assign load_byte = mem_rdata_wb[8*exec_result_wb[1:0] +: 8];
    assign load_half = mem_rdata_wb[16*exec_result_wb[1] +: 16];

    always_comb begin
        case (funct3)
            F3_B:    load_ext = {{(XLEN-8){load_byte[7]}}, load_byte};
            F3_BU:   load_ext = {{(XLEN-8){1'b0}}, load_byte};
            F3_H:    load_ext = {{(XLEN-16){load_half[15]}}, load_half};
            F3_HU:   load_ext = {{(XLEN-16){1'b0}}, load_half};
            F3_W:    load_ext = mem_rdata_wb;
            default: load_ext = mem_rdata_wb;
        endcase
    end

    assign is_load = mem_read_wb && (opcode == OP_LOAD);

    // register file write port
    assign rf_waddr = rd;
    assign rf_wdata = is_load ? load_ext : exec_result_wb;
    // x0 is never written, nothing is written once halted
    assign rf_we    = reg_write_wb && (rd != '0) && !halted;

    // sticky until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (!stall && ecall_wb) begin
            halted <= 1'b1;
        end
    end

    // bubbles are not counted
    assign retire = !stall && !halted && (instruction_wb != NOP_INSTR);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instret <= '0;
        end else if (retire) begin
            instret <= instret + 1'b1;
        end
    end

endmodule

/* mem_wb_subsys.sv */
`timescale 1ns/1ps

module mem_wb_subsys #(
    parameter int DMEM_WORDS = pipe_pkg::DMEM_WORDS_DEFAULT,
    parameter int INSTRET_W  = pipe_pkg::INSTRET_W
) (
    input  logic                              clk,
    input  logic                              rst_n,
    // EX/MEM controls
    input  logic                              stall,
    input  logic                              flush,
    input  logic                              reg_write,
    input  logic                              mem_read,
    input  logic                              mem_write,
    input  logic                              ecall,
    // EX/MEM values
    input  logic [rv_isa_pkg::XLEN-1:0]       instruction,
    input  logic [rv_isa_pkg::XLEN-1:0]       pc,
    input  logic [rv_isa_pkg::XLEN-1:0]       exec_result,
    input  logic [rv_isa_pkg::XLEN-1:0]       store_data,
    // register file write port
    output logic                              rf_we,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rf_waddr,
    output logic [rv_isa_pkg::XLEN-1:0]       rf_wdata,
    output logic                              halted,
    output logic [INSTRET_W-1:0]              instret
);
    import rv_isa_pkg::*;

    logic [XLEN-1:0] mem_rdata;
    logic            reg_write_wb;
    logic [XLEN-1:0] instruction_wb;
    logic [XLEN-1:0] exec_result_wb;
    logic            mem_read_wb;
    logic [XLEN-1:0] mem_rdata_wb;
    logic            ecall_wb;

    mem_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) mem_stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_write   (mem_write),
        .instruction (instruction),
        .exec_result (exec_result),
        .store_data  (store_data),
        .mem_rdata   (mem_rdata)
    );

    // pc is carried for debug visibility only, writeback has no use for it
    mem_wb_reg mem_wb_reg_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .flush          (flush),
        .reg_write      (reg_write),
        .instruction    (instruction),
        .pc             (pc),
        .exec_result    (exec_result),
        .mem_read       (mem_read),
        .mem_rdata      (mem_rdata),
        .ecall          (ecall),
        .reg_write_wb   (reg_write_wb),
        .instruction_wb (instruction_wb),
        .pc_wb          (),
        .exec_result_wb (exec_result_wb),
        .mem_read_wb    (mem_read_wb),
        .mem_rdata_wb   (mem_rdata_wb),
        .ecall_wb       (ecall_wb)
    );

    writeback_stage #(
        .INSTRET_W (INSTRET_W)
    ) writeback_stage_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .reg_write_wb   (reg_write_wb),
        .instruction_wb (instruction_wb),
        .exec_result_wb (exec_result_wb),
        .mem_read_wb    (mem_read_wb),
        .mem_rdata_wb   (mem_rdata_wb),
        .ecall_wb       (ecall_wb),
        .rf_we          (rf_we),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata),
        .halted         (halted),
        .instret        (instret)
    );

endmodule

/* tb_mem_wb_subsys.sv */
`timescale 1ns/1ps

module tb_mem_wb_subsys;
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_HALF     = 4;
    localparam int RESET_CYCLES = 10;

    logic                  clk;
    logic                  rst_n;
    logic                  stall;
    logic                  flush;
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  ecall;
    logic [XLEN-1:0]       instruction;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       exec_result;
    logic [XLEN-1:0]       store_data;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
    logic                  halted;
    logic [INSTRET_W-1:0]  instret;

    // one entry per vector line, controls packed as {stall, flush, rw, mr, mw, ecall}
    logic [5:0]            ctrl_q[$];
    logic [XLEN-1:0]       instr_q[$];
    logic [XLEN-1:0]       pc_q[$];
    logic [XLEN-1:0]       exec_q[$];
    logic [XLEN-1:0]       store_q[$];
    logic                  exp_we_q[$];
    logic [REG_ADDR_W-1:0] exp_waddr_q[$];
    logic [XLEN-1:0]       exp_wdata_q[$];
    logic                  exp_halted_q[$];
    logic [INSTRET_W-1:0]  exp_instret_q[$];

    int num_vec;
    int cycle_count;
    int cycle_limit;

    mem_wb_subsys #(
        .DMEM_WORDS (DMEM_WORDS_DEFAULT),
        .INSTRET_W  (INSTRET_W)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .flush       (flush),
        .reg_write   (reg_write),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .ecall       (ecall),
        .instruction (instruction),
        .pc          (pc),
        .exec_result (exec_result),
        .store_data  (store_data),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .halted      (halted),
        .instret     (instret)
    );

    always #CLK_HALF clk = ~clk;

    // run limit scales with the number of vectors
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic read_vectors();
        int              fd;
        int              n;
        string           line;
        logic [XLEN-1:0] c_stall, c_flush, c_rw, c_mr, c_mw, c_ec;
        logic [XLEN-1:0] c_instr, c_pc, c_exec, c_store;
        logic [XLEN-1:0] e_we, e_waddr, e_wdata, e_halted, e_instret;
        fd = $fopen("test_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file test_input.txt");
            $display("*** TEST FAILED ***");
            $fatal(1, "missing stimulus file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // comment lines and blank lines carry no vector
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                c_stall, c_flush, c_rw, c_mr, c_mw, c_ec,
                                c_instr, c_pc, c_exec, c_store,
                                e_we, e_waddr, e_wdata, e_halted, e_instret);
                    if (n == 15) begin
                        ctrl_q.push_back({c_stall[0], c_flush[0], c_rw[0],
                                          c_mr[0], c_mw[0], c_ec[0]});
                        instr_q.push_back(c_instr);
                        pc_q.push_back(c_pc);
                        exec_q.push_back(c_exec);
                        store_q.push_back(c_store);
                        exp_we_q.push_back(e_we[0]);
                        exp_waddr_q.push_back(e_waddr[REG_ADDR_W-1:0]);
                        exp_wdata_q.push_back(e_wdata);
                        exp_halted_q.push_back(e_halted[0]);
                        exp_instret_q.push_back(e_instret[INSTRET_W-1:0]);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_vector(input int idx);
        stall       <= ctrl_q[idx][5];
        flush       <= ctrl_q[idx][4];
        reg_write   <= ctrl_q[idx][3];
        mem_read    <= ctrl_q[idx][2];
        mem_write   <= ctrl_q[idx][1];
        ecall       <= ctrl_q[idx][0];
        instruction <= instr_q[idx];
        pc          <= pc_q[idx];
        exec_result <= exec_q[idx];
        store_data  <= store_q[idx];
    endtask

    // quiet bus after the last vector
    task automatic drive_idle();
        stall       <= 1'b0;
        flush       <= 1'b0;
        reg_write   <= 1'b0;
        mem_read    <= 1'b0;
        mem_write   <= 1'b0;
        ecall       <= 1'b0;
        instruction <= NOP_INSTR;
        pc          <= '0;
        exec_result <= '0;
        store_data  <= '0;
    endtask

    task automatic check_vector(input int idx);
        check_value($sformatf("vector %0d rf_we", idx), XLEN'(exp_we_q[idx]), XLEN'(rf_we));
        check_value($sformatf("vector %0d rf_waddr", idx), XLEN'(exp_waddr_q[idx]),
                    XLEN'(rf_waddr));
        check_value($sformatf("vector %0d rf_wdata", idx), exp_wdata_q[idx], rf_wdata);
        check_value($sformatf("vector %0d halted", idx), XLEN'(exp_halted_q[idx]),
                    XLEN'(halted));
        check_value($sformatf("vector %0d instret", idx), XLEN'(exp_instret_q[idx]),
                    XLEN'(instret));
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        ecall       = 1'b0;
        instruction = NOP_INSTR;
        pc          = '0;
        exec_result = '0;
        store_data  = '0;
        cycle_count = 0;
        cycle_limit = 100;

        read_vectors();
        num_vec     = exp_we_q.size();
        cycle_limit = 4 * num_vec + 100;
        if (num_vec == 0) begin
            $display("the stimulus file holds no vectors");
            $display("*** TEST FAILED ***");
            $fatal(1, "empty stimulus file");
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            // first vector goes out with the reset release
            rst_n <= 1'b1;
            drive_vector(0);
            for (int i = 0; i < num_vec; i++) begin
                @(posedge clk);
                if (i + 1 < num_vec) begin
                    drive_vector(i + 1);
                end else begin
                    drive_idle();
                end
                // vector i is now in the MEM/WB register
                @(negedge clk);
                check_vector(i);
            end
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

/* test_input.txt */
# stall flush reg_write mem_read mem_write ecall instruction pc exec_result store_data
# then expected rf_we rf_waddr rf_wdata halted instret, all hex, text after that is a note
0 0 1 0 0 0 12300293 00000100 00000123 00000000  1 05 00000123 0 00000000  # addi x5
0 0 1 0 0 0 00500013 00000104 00000005 00000000  0 00 00000005 0 00000001  # addi x0
0 0 1 0 0 0 00000fb3 00000108 deadbeef 00000000  1 1f deadbeef 0 00000002  # add x31
0 0 0 0 1 0 00002023 0000010c 00000040 cafef00d  0 00 00000040 0 00000003  # sw 0x40
0 0 1 1 0 0 00002303 00000110 00000040 00000000  1 06 cafef00d 0 00000004  # lw 0x40
0 0 0 0 1 0 00000023 00000114 00000080 000000a5  0 00 00000080 0 00000005  # sb 0x80
0 0 0 0 1 0 00000023 00000118 00000081 11223344  0 00 00000081 0 00000006  # sb 0x81
0 0 0 0 1 0 00001023 0000011c 00000082 ffff8c7e  0 00 00000082 0 00000007  # sh 0x82
0 0 1 1 0 0 00002303 00000120 00000080 00000000  1 06 8c7e44a5 0 00000008  # lw 0x80
0 0 1 1 0 0 00000383 00000124 00000080 00000000  1 07 ffffffa5 0 00000009  # lb +0
0 0 1 1 0 0 00000383 00000128 00000081 00000000  1 07 00000044 0 0000000a  # lb +1
0 0 1 1 0 0 00000383 0000012c 00000082 00000000  1 07 0000007e 0 0000000b  # lb +2
0 0 1 1 0 0 00000383 00000130 00000083 00000000  1 07 ffffff8c 0 0000000c  # lb +3
0 0 1 1 0 0 00004403 00000134 00000080 00000000  1 08 000000a5 0 0000000d  # lbu +0
0 0 1 1 0 0 00004403 00000138 00000081 00000000  1 08 00000044 0 0000000e  # lbu +1
0 0 1 1 0 0 00004403 0000013c 00000082 00000000  1 08 0000007e 0 0000000f  # lbu +2
0 0 1 1 0 0 00004403 00000140 00000083 00000000  1 08 0000008c 0 00000010  # lbu +3
0 0 1 1 0 0 00001483 00000144 00000080 00000000  1 09 000044a5 0 00000011  # lh +0
0 0 1 1 0 0 00001483 00000148 00000082 00000000  1 09 ffff8c7e 0 00000012  # lh +2
0 0 1 1 0 0 00005503 0000014c 00000080 00000000  1 0a 000044a5 0 00000013  # lhu +0
0 0 1 1 0 0 00005503 00000150 00000082 00000000  1 0a 00008c7e 0 00000014  # lhu +2
1 0 1 0 0 0 00000613 00000154 00000055 00000000  1 0a 00008c7e 0 00000014  # stall
1 0 1 0 0 0 00000613 00000154 00000055 00000000  1 0a 00008c7e 0 00000014  # stall
1 1 1 0 0 0 00000613 00000154 00000055 00000000  1 0a 00008c7e 0 00000014  # stall beats flush
0 0 1 0 0 0 00000613 00000154 00000055 00000000  1 0c 00000055 0 00000015  # addi x12
0 1 1 0 0 0 00000693 00000158 00000066 00000000  0 00 00000000 0 00000016  # flush
0 0 1 0 0 0 00000693 00000158 00000066 00000000  1 0d 00000066 0 00000016  # addi x13
0 0 0 0 0 1 00000073 0000015c 00000000 00000000  0 00 00000000 0 00000017  # ecall
0 0 1 0 0 0 00000713 00000160 00000077 00000000  0 0e 00000077 1 00000018  # addi x14
0 0 1 0 0 0 00000793 00000164 00000088 00000000  0 0f 00000088 1 00000018  # addi x15
0 0 1 1 0 0 00002303 00000168 00000040 00000000  0 06 cafef00d 1 00000018  # lw 0x40
1 0 1 0 0 0 00000813 0000016c 00000099 00000000  0 06 cafef00d 1 00000018  # stall halted

/* mem_wb_subsys.f */
rv_isa_pkg.sv
pipe_pkg.sv
mem_stage.sv
mem_wb_reg.sv
writeback_stage.sv
mem_wb_subsys.sv
tb_mem_wb_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the MEM/WB testbench with Verilator.
# The exit status is nonzero when the build fails or the testbench fails.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module tb_mem_wb_subsys \
    -f mem_wb_subsys.f \
    -Mdir obj_dir
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/Vtb_mem_wb_subsys
run_status=$?
if [ "$run_status" -ne 0 ]; then
    echo "simulation failed with status $run_status"
    exit "$run_status"
fi

echo "simulation finished with status 0"
exit 0
